// ==== design/board_settings.svh ====
// Board-level constants shared by the RTL and the testbench.
// Include in any file that needs pin count, reset timing or register offsets.
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// Header pins driven through the pin multiplexer
`define BOARD_HDR_PINS   8

// System reset hold after PLL lock, in clock cycles
`define BOARD_RST_HOLD   16

`define BOARD_PWM_WIDTH  8  // Counter, period and duty width

// Register offsets on the strobe bus
`define BOARD_REG_GPO    4'h0
`define BOARD_REG_GPI    4'h1  // Read only
`define BOARD_REG_HDR    4'h2  // Read only
`define BOARD_REG_PINSEL 4'h3
`define BOARD_REG_PWM    4'h4  // Period in 15..8, duty in 7..0

// Per-pin modes, anything else is input
`define BOARD_PIN_GPIO   2'd1
`define BOARD_PIN_PWM    2'd2

`endif

// ==== design/board_pkg.sv ====
// Shared types for the board I/O subsystem.
// Modules import this package inside their body and use scoped names on ports.
`default_nettype none

`include "board_settings.svh"

package board_pkg;

  // Register strobe bus
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // LEDs in 7..0, header GPIO source in 15..8
  typedef logic [15:0] gpo_word_t;

  // Select switches 15..13, user switches 12..5, nav switches 4..0
  typedef logic [15:0] gpi_word_t;

  typedef logic [`BOARD_HDR_PINS-1:0] hdr_word_t;  // One bit per header pin

  // 0 input, 1 GPIO, 2 PWM, 3 reserved and treated as input
  typedef logic [1:0] pin_sel_t;
  typedef logic [2*`BOARD_HDR_PINS-1:0] pinsel_word_t;

  typedef logic [`BOARD_PWM_WIDTH-1:0] pwm_cnt_t;

  // Reset controller FSM
  typedef enum logic [1:0] {
    RST_WAIT_LOCK = 2'd0,
    RST_HOLD      = 2'd1,
    RST_RUN       = 2'd2
  } rst_state_e;

endpackage

`default_nettype wire

// ==== design/rst_ctrl.sv ====
// System reset generator. Waits for PLL lock, then holds reset for a fixed
// number of cycles before releasing it synchronously.
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module rst_ctrl (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic pll_locked_i,
  output logic rst_sys_n_o
);
  import board_pkg::*;

  localparam int unsigned HoldCntW = $clog2(`BOARD_RST_HOLD);

  logic                lock_meta;
  logic                lock_sync;
  rst_state_e          state_q;
  logic [HoldCntW-1:0] hold_cnt;
  logic                rst_sys_n_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_meta   <= 1'b0;
      lock_sync   <= 1'b0;
      state_q     <= RST_WAIT_LOCK;
      hold_cnt    <= '0;
      rst_sys_n_q <= 1'b0;
    end else begin
      lock_meta <= pll_locked_i;  // Lock is asynchronous to clk_i
      lock_sync <= lock_meta;
      case (state_q)
        RST_WAIT_LOCK: begin
          hold_cnt    <= '0;
          rst_sys_n_q <= 1'b0;
          if (lock_sync) state_q <= RST_HOLD;
        end
        RST_HOLD: begin
          if (!lock_sync) begin
            state_q <= RST_WAIT_LOCK;
          end else if (hold_cnt == HoldCntW'(`BOARD_RST_HOLD - 1)) begin
            state_q     <= RST_RUN;
            rst_sys_n_q <= 1'b1;  // Release on the last hold cycle
          end else begin
            hold_cnt <= hold_cnt + 1'b1;
          end
        end
        default: begin
          // Lock loss pulls reset straight back down
          if (!lock_sync) begin
            state_q     <= RST_WAIT_LOCK;
            rst_sys_n_q <= 1'b0;
          end
        end
      endcase
    end
  end

  assign rst_sys_n_o = rst_sys_n_q;

endmodule

`default_nettype wire

// ==== design/switch_sync.sv ====
// Input stage for the board switches and header pins.
// Inverts the pulled-up switches and synchronises everything with two flops.
`timescale 1ns/1ps
`default_nettype none

module switch_sync (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic [4:0]           nav_sw_i,
  input  logic [7:0]           usr_sw_i,
  input  logic [2:0]           sel_sw_i,
  input  board_pkg::hdr_word_t hdr_i,
  output board_pkg::gpi_word_t gpi_o,
  output board_pkg::hdr_word_t hdr_sync_o
);
  import board_pkg::*;

  gpi_word_t gpi_raw;
  gpi_word_t gpi_meta;
  gpi_word_t gpi_q;
  hdr_word_t hdr_meta;
  hdr_word_t hdr_q;

  // Switches pull to ground when on
  assign gpi_raw = {~sel_sw_i, ~usr_sw_i, ~nav_sw_i};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpi_meta <= '0;
      gpi_q    <= '0;
      hdr_meta <= '0;
      hdr_q    <= '0;
    end else begin
      gpi_meta <= gpi_raw;
      gpi_q    <= gpi_meta;
      hdr_meta <= hdr_i;  // Header inputs are already active high
      hdr_q    <= hdr_meta;
    end
  end

  assign gpi_o      = gpi_q;
  assign hdr_sync_o = hdr_q;

endmodule

`default_nettype wire

// ==== design/gpio_regs.sv ====
// Register block on the strobe bus. Holds the GPO word, header pin modes and
// PWM settings, and reads back the synchronised switches and header pins.
// Read data is registered and valid one cycle after the read strobe.
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module gpio_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    reg_we_i,
  input  logic                    reg_re_i,
  input  board_pkg::reg_addr_t    reg_addr_i,
  input  board_pkg::reg_data_t    reg_wdata_i,
  output board_pkg::reg_data_t    reg_rdata_o,
  output logic                    reg_rvalid_o,
  input  board_pkg::gpi_word_t    gpi_i,
  input  board_pkg::hdr_word_t    hdr_sync_i,
  output board_pkg::gpo_word_t    gpo_o,
  output board_pkg::pinsel_word_t pinsel_o,
  output board_pkg::pwm_cnt_t     pwm_period_o,
  output board_pkg::pwm_cnt_t     pwm_duty_o
);
  import board_pkg::*;

  localparam int unsigned PwmW = `BOARD_PWM_WIDTH;

  gpo_word_t    gpo_q;
  pinsel_word_t pinsel_q;
  pwm_cnt_t     period_q;
  pwm_cnt_t     duty_q;
  reg_data_t    rdata_d;
  reg_data_t    rdata_q;
  logic         rvalid_q;

  // Writes to read-only and unmapped offsets are ignored
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q    <= '0;
      pinsel_q <= '0;  // All pins in input mode
      period_q <= '0;
      duty_q   <= '0;
    end else if (reg_we_i) begin
      case (reg_addr_i)
        `BOARD_REG_GPO:    gpo_q    <= reg_wdata_i[15:0];
        `BOARD_REG_PINSEL: pinsel_q <= reg_wdata_i[15:0];
        `BOARD_REG_PWM: begin
          period_q <= reg_wdata_i[2*PwmW-1:PwmW];
          duty_q   <= reg_wdata_i[PwmW-1:0];
        end
        default: ;
      endcase
    end
  end

  // Read mux sees register state before any same-cycle write
  always_comb begin
    rdata_d = '0;
    case (reg_addr_i)
      `BOARD_REG_GPO:    rdata_d = reg_data_t'(gpo_q);
      `BOARD_REG_GPI:    rdata_d = reg_data_t'(gpi_i);
      `BOARD_REG_HDR:    rdata_d = reg_data_t'(hdr_sync_i);
      `BOARD_REG_PINSEL: rdata_d = reg_data_t'(pinsel_q);
      `BOARD_REG_PWM:    rdata_d = reg_data_t'({period_q, duty_q});
      default:           rdata_d = '0;  // Unmapped
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= reg_re_i;
    end
  end

  // Read data updates only on a read strobe
  always_ff @(posedge clk_i) begin
    if (reg_re_i) rdata_q <= rdata_d;
  end

  assign reg_rdata_o  = rdata_q;
  assign reg_rvalid_o = rvalid_q;
  assign gpo_o        = gpo_q;
  assign pinsel_o     = pinsel_q;
  assign pwm_period_o = period_q;
  assign pwm_duty_o   = duty_q;

endmodule

`default_nettype wire

// ==== design/pwm_gen.sv ====
// Single-channel PWM. Counter runs 0..period and wraps; period and duty are
// sampled into shadow registers at each wrap so changes never glitch a cycle.
`timescale 1ns/1ps
`default_nettype none

module pwm_gen (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  board_pkg::pwm_cnt_t period_i,
  input  board_pkg::pwm_cnt_t duty_i,
  output logic                pwm_o
);
  import board_pkg::*;

  pwm_cnt_t cnt_q, cnt_d;
  pwm_cnt_t period_q, period_d;
  pwm_cnt_t duty_q, duty_d;
  logic     pwm_q;
  logic     wrap;

  assign wrap = (cnt_q == period_q);

  always_comb begin
    cnt_d    = wrap ? '0 : cnt_q + 1'b1;
    period_d = wrap ? period_i : period_q;  // Shadow load at wrap
    duty_d   = wrap ? duty_i : duty_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q    <= '0;
      period_q <= '0;
      duty_q   <= '0;
      pwm_q    <= 1'b0;
    end else begin
      cnt_q    <= cnt_d;
      period_q <= period_d;
      duty_q   <= duty_d;
      pwm_q    <= (period_d != '0) && (cnt_d < duty_d);  // Zero period holds low
    end
  end

  assign pwm_o = pwm_q;

endmodule

`default_nettype wire

// ==== design/pinmux.sv ====
// Header pin multiplexer. Each pin's 2-bit mode picks GPIO, PWM or input.
// Purely combinational, header outputs follow the registers directly.
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module pinmux (
  input  board_pkg::hdr_word_t    gpio_i,
  input  logic                    pwm_i,
  input  board_pkg::pinsel_word_t pinsel_i,
  output board_pkg::hdr_word_t    hdr_o,
  output board_pkg::hdr_word_t    hdr_oe_o
);
  import board_pkg::*;

  always_comb begin
    pin_sel_t mode;
    hdr_o    = '0;
    hdr_oe_o = '0;
    for (int i = 0; i < `BOARD_HDR_PINS; i++) begin
      mode = pinsel_i[2*i +: 2];
      case (mode)
        `BOARD_PIN_GPIO: begin
          hdr_oe_o[i] = 1'b1;
          hdr_o[i]    = gpio_i[i];
        end
        `BOARD_PIN_PWM: begin
          hdr_oe_o[i] = 1'b1;
          hdr_o[i]    = pwm_i;  // One PWM shared by all pins
        end
        default: begin
          // Input or reserved, pin released and driven value low
          hdr_oe_o[i] = 1'b0;
          hdr_o[i]    = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/board_top.sv ====
// Top level of the board I/O subsystem. Connects reset control, switch
// inputs, the register block, PWM and the header pin multiplexer.
`timescale 1ns/1ps
`default_nettype none

module board_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 pll_locked_i,
  input  logic [4:0]           nav_sw_i,
  input  logic [7:0]           usr_sw_i,
  input  logic [2:0]           sel_sw_i,
  input  board_pkg::hdr_word_t hdr_i,
  input  logic                 reg_we_i,
  input  logic                 reg_re_i,
  input  board_pkg::reg_addr_t reg_addr_i,
  input  board_pkg::reg_data_t reg_wdata_i,
  output board_pkg::reg_data_t reg_rdata_o,
  output logic                 reg_rvalid_o,
  output logic [7:0]           usr_led_o,
  output board_pkg::hdr_word_t hdr_o,
  output board_pkg::hdr_word_t hdr_oe_o,
  output logic                 led_bootok_o
);
  import board_pkg::*;

  logic         rst_sys_n;
  gpi_word_t    gpi;
  hdr_word_t    hdr_in_sync;
  gpo_word_t    gpo;
  pinsel_word_t pinsel;
  pwm_cnt_t     pwm_period;
  pwm_cnt_t     pwm_duty;
  logic         pwm_out;

  assign led_bootok_o = rst_sys_n;  // Lit once the system is out of reset
  assign usr_led_o    = gpo[7:0];

  rst_ctrl u_rst_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .pll_locked_i(pll_locked_i),
    .rst_sys_n_o (rst_sys_n)
  );

  switch_sync u_switch_sync (
    .clk_i     (clk_i),
    .rst_n_i   (rst_sys_n),
    .nav_sw_i  (nav_sw_i),
    .usr_sw_i  (usr_sw_i),
    .sel_sw_i  (sel_sw_i),
    .hdr_i     (hdr_i),
    .gpi_o     (gpi),
    .hdr_sync_o(hdr_in_sync)
  );

  gpio_regs u_gpio_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_sys_n),
    .reg_we_i    (reg_we_i),
    .reg_re_i    (reg_re_i),
    .reg_addr_i  (reg_addr_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_rvalid_o(reg_rvalid_o),
    .gpi_i       (gpi),
    .hdr_sync_i  (hdr_in_sync),
    .gpo_o       (gpo),
    .pinsel_o    (pinsel),
    .pwm_period_o(pwm_period),
    .pwm_duty_o  (pwm_duty)
  );

  pwm_gen u_pwm_gen (
    .clk_i   (clk_i),
    .rst_n_i (rst_sys_n),
    .period_i(pwm_period),
    .duty_i  (pwm_duty),
    .pwm_o   (pwm_out)
  );

  // Upper GPO byte is the GPIO source for the header
  pinmux u_pinmux (
    .gpio_i  (gpo[15:8]),
    .pwm_i   (pwm_out),
    .pinsel_i(pinsel),
    .hdr_o   (hdr_o),
    .hdr_oe_o(hdr_oe_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_board_top.sv ====
// Random-stimulus testbench for the board I/O subsystem.
// Steps through reset sequencing, register, switch, pin mux and PWM tests and
// compares the DUT each cycle against a register-level model kept here.
`timescale 1ns/1ps
`default_nettype none

`include "board_settings.svh"

module tb_board_top;
  import board_pkg::*;

  localparam int N_GPO = 24;
  localparam int N_SW  = 16;
  localparam int N_PIN = 16;
  localparam int N_PWM = 6;
  localparam int N_MIX = 400;
  localparam int BOOT_EDGES = 3 + `BOARD_RST_HOLD;  // Two sync flops, FSM edge, then hold
  // Upper bounds per test, a PWM trial waits at most two 256-cycle periods
  localparam int PLAN_CYCLES = 2 * (20 + 2 * BOOT_EDGES) + N_GPO * 3 + N_SW * 4
                               + N_PIN * 9 + N_PWM * 780 + N_MIX + 10;
  localparam int CYCLE_LIMIT = PLAN_CYCLES + 200;

  logic         clk_i;
  logic         rst_n_i;
  logic         pll_locked_i;
  logic [4:0]   nav_sw_i;
  logic [7:0]   usr_sw_i;
  logic [2:0]   sel_sw_i;
  hdr_word_t    hdr_i;
  logic         reg_we_i;
  logic         reg_re_i;
  reg_addr_t    reg_addr_i;
  reg_data_t    reg_wdata_i;
  reg_data_t    reg_rdata_o;
  logic         reg_rvalid_o;
  logic [7:0]   usr_led_o;
  hdr_word_t    hdr_o;
  hdr_word_t    hdr_oe_o;
  logic         led_bootok_o;

  // Input values for the next drive edge
  logic [4:0]   nxt_nav;
  logic [7:0]   nxt_usr;
  logic [2:0]   nxt_sel;
  hdr_word_t    nxt_hdr;

  // Reference model state
  gpo_word_t    m_gpo;
  pinsel_word_t m_pinsel;
  pwm_cnt_t     m_period, m_duty;
  pwm_cnt_t     m_cnt, m_pper, m_pduty;
  logic         m_pwm;
  gpi_word_t    m_gpi1, m_gpi2;
  hdr_word_t    m_hdr1, m_hdr2;
  logic         m_rvalid;
  reg_data_t    m_rdata;

  int seed = 66482;
  int reg_errs, hdr_errs, led_errs, flag_errs, count_errs;
  int cyc;

  board_top u_dut (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .pll_locked_i(pll_locked_i),
    .nav_sw_i(nav_sw_i), .usr_sw_i(usr_sw_i), .sel_sw_i(sel_sw_i), .hdr_i(hdr_i),
    .reg_we_i(reg_we_i), .reg_re_i(reg_re_i), .reg_addr_i(reg_addr_i),
    .reg_wdata_i(reg_wdata_i), .reg_rdata_o(reg_rdata_o), .reg_rvalid_o(reg_rvalid_o),
    .usr_led_o(usr_led_o), .hdr_o(hdr_o), .hdr_oe_o(hdr_oe_o), .led_bootok_o(led_bootok_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic reg_data_t rand_word();
    return reg_data_t'($random(seed));
  endfunction

  task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      reg_errs++;
    end
  endtask

  task automatic check_hdr(input string name, input hdr_word_t got, input hdr_word_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      hdr_errs++;
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      led_errs++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      flag_errs++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      count_errs++;
    end
  endtask

  task automatic quiet_outputs();
    check_led("usr_led_o", usr_led_o, 8'h00);
    check_hdr("hdr_oe_o", hdr_oe_o, '0);
    check_hdr("hdr_o", hdr_o, '0);
    check_flag("reg_rvalid_o", reg_rvalid_o, 1'b0);
  endtask

  // Cycles with the system held in reset
  task automatic idle_in_reset(input int n);
    repeat (n) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_flag("led_bootok_o", led_bootok_o, 1'b0);
      quiet_outputs();
    end
  endtask

  task automatic boot_after_lock();
    @(posedge clk_i);
    pll_locked_i <= 1'b1;
    for (int i = 1; i <= BOOT_EDGES; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_flag("led_bootok_o", led_bootok_o, i == BOOT_EDGES);
      if (i < BOOT_EDGES) quiet_outputs();
    end
  endtask

  task automatic model_reset();
    m_gpo = '0;
    m_pinsel = '0;
    m_period = '0;
    m_duty = '0;
    m_cnt = '0;
    m_pper = '0;
    m_pduty = '0;
    m_pwm = 1'b0;
    m_gpi1 = '0;
    m_gpi2 = '0;
    m_hdr1 = '0;
    m_hdr2 = '0;
    m_rvalid = 1'b0;
  endtask

  // Advance the model with the inputs sampled at this edge
  task automatic model_edge();
    m_rvalid = reg_re_i;
    if (reg_re_i) begin  // Read returns the value before this edge
      case (reg_addr_i)
        `BOARD_REG_GPO:    m_rdata = reg_data_t'(m_gpo);
        `BOARD_REG_GPI:    m_rdata = reg_data_t'(m_gpi2);
        `BOARD_REG_HDR:    m_rdata = reg_data_t'(m_hdr2);
        `BOARD_REG_PINSEL: m_rdata = reg_data_t'(m_pinsel);
        `BOARD_REG_PWM:    m_rdata = reg_data_t'({m_period, m_duty});
        default:           m_rdata = '0;
      endcase
    end
    // PWM wraps after reaching the period and takes new settings there
    if (m_cnt == m_pper) begin
      m_cnt   = '0;
      m_pper  = m_period;
      m_pduty = m_duty;
    end else begin
      m_cnt = m_cnt + 8'd1;
    end
    m_pwm = (m_pper != '0) && (m_cnt < m_pduty);
    if (reg_we_i) begin
      case (reg_addr_i)
        `BOARD_REG_GPO:    m_gpo = reg_wdata_i[15:0];
        `BOARD_REG_PINSEL: m_pinsel = reg_wdata_i[15:0];
        `BOARD_REG_PWM: begin
          m_period = reg_wdata_i[15:8];
          m_duty   = reg_wdata_i[7:0];
        end
        default: ;
      endcase
    end
    m_gpi2 = m_gpi1;  // Two-deep synchroniser delay
    m_gpi1 = {~sel_sw_i, ~usr_sw_i, ~nav_sw_i};
    m_hdr2 = m_hdr1;
    m_hdr1 = hdr_i;
  endtask

  task automatic compare_all();
    hdr_word_t exp_oe;
    hdr_word_t exp_val;
    exp_oe  = '0;
    exp_val = '0;
    for (int i = 0; i < `BOARD_HDR_PINS; i++) begin
      if (m_pinsel[2*i +: 2] == `BOARD_PIN_GPIO) begin
        exp_oe[i]  = 1'b1;
        exp_val[i] = m_gpo[8+i];
      end else if (m_pinsel[2*i +: 2] == `BOARD_PIN_PWM) begin
        exp_oe[i]  = 1'b1;
        exp_val[i] = m_pwm;
      end
    end
    check_flag("led_bootok_o", led_bootok_o, 1'b1);
    check_flag("reg_rvalid_o", reg_rvalid_o, m_rvalid);
    if (m_rvalid) check_reg("reg_rdata_o", reg_rdata_o, m_rdata);
    check_led("usr_led_o", usr_led_o, m_gpo[7:0]);
    check_hdr("hdr_oe_o", hdr_oe_o, exp_oe);
    check_hdr("hdr_o", hdr_o, exp_val);
  endtask

  task automatic bus_cycle(input logic we, input logic re, input reg_addr_t addr,
                           input reg_data_t wdata);
    @(posedge clk_i);
    model_edge();
    reg_we_i    <= we;
    reg_re_i    <= re;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    nav_sw_i    <= nxt_nav;
    usr_sw_i    <= nxt_usr;
    sel_sw_i    <= nxt_sel;
    hdr_i       <= nxt_hdr;
    @(negedge clk_i);
    compare_all();
  endtask

  task automatic shuffle_inputs();
    reg_data_t w;
    w = rand_word();
    nxt_nav = w[4:0];
    nxt_usr = w[12:5];
    nxt_sel = w[15:13];
    nxt_hdr = w[23:16];
  endtask

  initial begin
    reg_data_t r;
    pwm_cnt_t  per, duty;
    int        high, exp_high;
    rst_n_i      <= 1'b0;
    pll_locked_i <= 1'b0;
    reg_we_i     <= 1'b0;
    reg_re_i     <= 1'b0;
    reg_addr_i   <= '0;
    reg_wdata_i  <= '0;
    nav_sw_i     <= '1;  // Pulled up, switches off
    usr_sw_i     <= '1;
    sel_sw_i     <= '1;
    hdr_i        <= '0;
    nxt_nav = '1;
    nxt_usr = '1;
    nxt_sel = '1;
    nxt_hdr = '0;

    // Reset, lock, lock loss and relock
    idle_in_reset(16);
    @(posedge clk_i);
    rst_n_i <= 1'b1;
    idle_in_reset(4);
    boot_after_lock();
    @(posedge clk_i);
    pll_locked_i <= 1'b0;
    for (int i = 1; i <= 3; i++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      check_flag("led_bootok_o", led_bootok_o, i < 3);
    end
    idle_in_reset(4);
    boot_after_lock();
    model_reset();

    for (int n = 0; n < N_GPO; n++) begin
      bus_cycle(1'b1, 1'b0, `BOARD_REG_GPO, rand_word());
      bus_cycle(1'b1, 1'b0, reg_addr_t'(`BOARD_REG_GPI + n % 2), rand_word());  // Read only
      bus_cycle(1'b0, 1'b1, `BOARD_REG_GPO, '0);
    end

    for (int n = 0; n < N_SW; n++) begin
      shuffle_inputs();
      repeat (3) bus_cycle(1'b0, 1'b0, '0, '0);
      bus_cycle(1'b0, 1'b1, `BOARD_REG_GPI, '0);
    end

    for (int n = 0; n < N_PIN; n++) begin
      bus_cycle(1'b1, 1'b0, `BOARD_REG_PINSEL, rand_word());
      bus_cycle(1'b1, 1'b0, `BOARD_REG_GPO, rand_word());
      bus_cycle(1'b1, 1'b0, `BOARD_REG_PWM, rand_word() & 32'h0f0f);
      shuffle_inputs();
      repeat (3) bus_cycle(1'b0, 1'b0, '0, '0);
      bus_cycle(1'b0, 1'b1, `BOARD_REG_HDR, '0);
    end

    // Every pin on PWM, count high cycles over one period
    bus_cycle(1'b1, 1'b0, `BOARD_REG_PINSEL, 32'h0000_aaaa);
    for (int n = 0; n < N_PWM; n++) begin
      r = rand_word();
      per  = (n == 0) ? 8'h00 : r[15:8];
      duty = r[7:0];
      bus_cycle(1'b1, 1'b0, `BOARD_REG_PWM, reg_data_t'({per, duty}));
      bus_cycle(1'b0, 1'b0, '0, '0);
      while (!(m_cnt == '0 && m_pper == per && m_pduty == duty)) begin
        bus_cycle(1'b0, 1'b0, '0, '0);
      end
      high = 0;
      for (int k = 0; k <= int'(per); k++) begin
        if (k > 0) bus_cycle(1'b0, 1'b0, '0, '0);
        if (hdr_o[0]) high++;
      end
      exp_high = (per == '0) ? 0 : ((int'(duty) < int'(per) + 1) ? int'(duty) : int'(per) + 1);
      check_count("hdr_o[0] high cycles", high, exp_high);
    end

    // Mixed traffic with back-to-back and same-cycle strobes
    for (int n = 0; n < N_MIX; n++) begin
      r = rand_word();
      if (r[20:18] == 3'd0) shuffle_inputs();
      bus_cycle(r[8], r[9], r[13] ? r[17:14] : {1'b0, r[12:10]}, rand_word());
    end
    repeat (2) bus_cycle(1'b0, 1'b0, '0, '0);

    $display("Error counts reg %0d hdr %0d led %0d flag %0d count %0d",
             reg_errs, hdr_errs, led_errs, flag_errs, count_errs);
    if (reg_errs + hdr_errs + led_errs + flag_errs + count_errs == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    cyc = 0;
    while (cyc < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cyc++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/board_pkg.sv
design/rst_ctrl.sv
design/switch_sync.sv
design/gpio_regs.sv
design/pwm_gen.sv
design/pinmux.sv
design/board_top.sv
testbench/tb_board_top.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator, run the testbench and look for the pass line
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal -f src.f --top-module tb_board_top \
  && out=$(./obj_dir/Vtb_board_top) \
  && echo "$out" \
  && echo "$out" | grep -qx "NO ERRORS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
